// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== lsu_top.f ====
rtl/lsu_pkg.sv
rtl/lsu_m1_stage.sv
rtl/lsu_store_buffer.sv
rtl/lsu_m2_ctrl.sv
rtl/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// ==== rtl/lsu_m1_stage.sv ====
// tag/data SRAMs must return data one cycle after the address; the request must stay valid until accepted
`timescale 1ns/1ns

module lsu_m1_stage (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              lsu_req_valid_i,
    output logic                                              lsu_req_ready_o,
    input  lsu_pkg::lsu_req_t                                 lsu_req_i,
    output logic [lsu_pkg::OFFSET_W-1:0]                      sram_addr_o,
    input  lsu_pkg::cache_tag_t [lsu_pkg::NUM_WAYS-1:0]       sram_tag_i,
    input  logic [lsu_pkg::NUM_WAYS-1:0][lsu_pkg::DATA_W-1:0] sram_data_i,
    input  logic                                              m2_ready_i,
    input  lsu_pkg::sb_entry_t [lsu_pkg::SB_DEPTH-1:0]        sb_entries_i,
    input  logic [lsu_pkg::SB_DEPTH-1:0]                      sb_valid_i,
    output logic                                              m1_valid_o,
    output lsu_pkg::m1_pack_t                                 m1_o
);

    // request side, paired with the SRAM read in flight
    logic                 s0_valid_q;
    lsu_pkg::lsu_req_t    s0_req_q;
    logic [lsu_pkg::ADDR_W-1:0] sram_va;

    // M1 register
    logic                                              m1_valid_q;
    logic                                              m1_adv;
    lsu_pkg::lsu_req_t                                 m1_req_q;
    lsu_pkg::cache_tag_t [lsu_pkg::NUM_WAYS-1:0]       m1_tag_q;
    logic [lsu_pkg::NUM_WAYS-1:0][lsu_pkg::DATA_W-1:0] m1_data_q;

    assign m1_adv          = !m1_valid_q || m2_ready_i;
    assign lsu_req_ready_o = !s0_valid_q || m1_adv;
    assign m1_valid_o      = m1_valid_q;

    // while stalled, re-read the held request so the SRAM output stays aligned with it
    assign sram_va     = lsu_req_ready_o ? lsu_req_i.addr : s0_req_q.addr;
    assign sram_addr_o = {sram_va[lsu_pkg::TAG_LSB-1:lsu_pkg::LINE_LSB],  // line index
                          sram_va[lsu_pkg::LINE_LSB-1:0]};                // word in line

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s0_valid_q <= 1'b0;
            m1_valid_q <= 1'b0;
        end else begin
            if (lsu_req_ready_o) begin
                s0_valid_q <= lsu_req_valid_i;
            end
            if (m1_adv) begin
                m1_valid_q <= s0_valid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_req_ready_o) begin
            s0_req_q <= lsu_req_i;
        end
        if (m1_adv) begin
            m1_req_q  <= s0_req_q;
            m1_tag_q  <= sram_tag_i;   // SRAM output belongs to s0 here
            m1_data_q <= sram_data_i;
        end
    end

    always_comb begin
        m1_o.req  = m1_req_q;
        m1_o.data = m1_data_q;

        // halfword needs bit 0 clear, word needs both low bits clear
        case (m1_req_q.msize)
            2'd0:    m1_o.ale = 1'b0;
            2'd1:    m1_o.ale = m1_req_q.addr[0];
            default: m1_o.ale = |m1_req_q.addr[1:0];
        endcase

        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++) begin
            m1_o.rhit[w] = m1_tag_q[w].rp &&
                           (m1_tag_q[w].p == m1_req_q.addr[lsu_pkg::ADDR_W-1:lsu_pkg::TAG_LSB]);
        end

        // word match against live buffer contents, re-evaluated every cycle M1 waits
        for (int i = 0; i < lsu_pkg::SB_DEPTH; i++) begin
            m1_o.sb_hit[i] = sb_valid_i[i] &&
                (sb_entries_i[i].addr[lsu_pkg::ADDR_W-1:2] == m1_req_q.addr[lsu_pkg::ADDR_W-1:2]);
        end
    end

endmodule

// ==== rtl/lsu_m2_ctrl.sv ====
// loads miss only on aligned cached access; at most one buffered store may match a load's word
`timescale 1ns/1ns

module lsu_m2_ctrl (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       m1_valid_i,
    input  lsu_pkg::m1_pack_t                          m1_i,
    input  logic                                       sb_full_i,
    input  lsu_pkg::sb_entry_t [lsu_pkg::SB_DEPTH-1:0] sb_entries_i,
    input  logic [lsu_pkg::SB_DEPTH-1:0]               sb_valid_i,
    input  logic                                       commit_i,
    input  logic                                       lsu_resp_ready_i,
    input  lsu_pkg::bus_resp_t                         bus_resp_i,
    output logic                                       m2_ready_o,
    output logic                                       sb_push_o,
    output lsu_pkg::sb_entry_t                         sb_push_entry_o,
    output logic                                       lsu_resp_valid_o,
    output lsu_pkg::lsu_resp_t                         lsu_resp_o,
    output lsu_pkg::bus_req_t                          bus_req_o
);

    typedef enum logic [1:0] {
        S_NORMAL,
        S_WAITSB,   // store overlaps a buffered word
        S_REFILL,   // load miss, bus request out
        S_RFLDONE   // refill word held, respond
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    logic                       m2_valid_q;
    lsu_pkg::m1_pack_t          m2_q;
    logic [lsu_pkg::DATA_W-1:0] rfl_q;

    logic resp_ok;   // response register can take a new item
    logic m2_done;   // M2 item answers this cycle
    logic m2_store;
    logic m2_miss;
    logic m2_wait;
    logic sb_block;  // M1 store would overflow the buffer

    logic [lsu_pkg::STRB_W-1:0] fwd_strb;
    logic [lsu_pkg::DATA_W-1:0] fwd_data;
    logic [lsu_pkg::DATA_W-1:0] merged;
    logic [lsu_pkg::DATA_W-1:0] shifted;
    lsu_pkg::lsu_resp_t         resp_d;

    assign resp_ok  = !lsu_resp_valid_o || lsu_resp_ready_i;
    assign m2_store = |m2_q.req.strb;
    assign m2_miss  = !m2_store && !m2_q.ale && !(|m2_q.rhit);
    assign m2_wait  = m2_store && !m2_q.ale && (|(m2_q.sb_hit & sb_valid_i));
    assign sb_block = m1_valid_i && (|m1_i.req.strb) && !m1_i.ale && sb_full_i;

    assign m2_ready_o = (!m2_valid_q || m2_done) && !sb_block;
    assign sb_push_o  = m2_ready_o && m1_valid_i && (|m1_i.req.strb) && !m1_i.ale;

    assign sb_push_entry_o.addr  = m1_i.req.addr;
    assign sb_push_entry_o.strb  = m1_i.req.strb;
    assign sb_push_entry_o.wdata = m1_i.req.wdata;
    assign sb_push_entry_o.way   = m1_i.rhit;
    assign sb_push_entry_o.hit   = |m1_i.rhit;

    always_comb begin
        state_d   = state_q;
        m2_done   = 1'b0;
        bus_req_o = '0;
        case (state_q)
            S_NORMAL: begin
                if (m2_valid_q) begin
                    if (m2_miss) begin
                        state_d = S_REFILL;
                    end else if (m2_wait) begin
                        state_d = S_WAITSB;
                    end else begin
                        m2_done = resp_ok;  // hit, store or misaligned
                    end
                end
            end
            S_WAITSB: begin
                if (commit_i) begin
                    state_d = S_NORMAL;  // recheck against remaining entries
                end
            end
            S_REFILL: begin
                bus_req_o.valid = 1'b1;
                bus_req_o.addr  = m2_q.req.addr;
                if (bus_resp_i.ready) begin
                    state_d = S_RFLDONE;
                end
            end
            default: begin
                m2_done = resp_ok;
                if (resp_ok) begin
                    state_d = S_NORMAL;
                end
            end
        endcase
    end

    // load data: pick word, overlay forwarded bytes, shift down, extend
    always_comb begin
        merged   = '0;
        fwd_strb = '0;
        fwd_data = '0;
        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++) begin
            if (m2_q.rhit[w]) begin
                merged |= m2_q.data[w];
            end
        end
        if (state_q == S_RFLDONE) begin
            merged = rfl_q;
        end
        for (int i = 0; i < lsu_pkg::SB_DEPTH; i++) begin
            if (m2_q.sb_hit[i]) begin
                fwd_strb |= sb_entries_i[i].strb;
                fwd_data |= sb_entries_i[i].wdata;
            end
        end
        for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
            if (fwd_strb[b]) begin
                merged[8*b +: 8] = fwd_data[8*b +: 8];
            end
        end
        shifted = merged >> {m2_q.req.addr[1:0], 3'b000};

        resp_d.wid  = m2_q.req.wid;
        resp_d.addr = m2_q.req.addr;
        resp_d.ale  = m2_q.ale;
        case (m2_q.req.msize)
            2'd0:    resp_d.rdata = {{24{m2_q.req.msigned & shifted[7]}}, shifted[7:0]};
            2'd1:    resp_d.rdata = {{16{m2_q.req.msigned & shifted[15]}}, shifted[15:0]};
            default: resp_d.rdata = shifted;
        endcase
        if (m2_store) begin
            resp_d.rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q          <= S_NORMAL;
            m2_valid_q       <= 1'b0;
            lsu_resp_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (m2_ready_o) begin
                m2_valid_q <= m1_valid_i;
            end else if (m2_done) begin
                m2_valid_q <= 1'b0;  // answered, M1 store held back by full buffer
            end
            if (resp_ok) begin
                lsu_resp_valid_o <= m2_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m2_ready_o) begin
            m2_q <= m1_i;
        end
        if (resp_ok) begin
            lsu_resp_o <= resp_d;
        end
        if (state_q == S_REFILL && bus_resp_i.ready) begin
            rfl_q <= bus_resp_i.rdata;
        end
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
// no address translation, so physical equals virtual; the SRAMs see only the low 12 address bits
package lsu_pkg;

    localparam int NUM_WAYS = 4;   // cache associativity
    localparam int SB_DEPTH = 4;   // store buffer entries
    localparam int SB_PTR_W = 2;
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = 4;
    localparam int OFFSET_W = 12;  // index + offset bits to the SRAMs
    localparam int LINE_LSB = 4;   // first bit of the line index
    localparam int TAG_LSB  = 12;  // first bit of the physical tag
    localparam int WID_W    = 6;   // writeback id

    typedef struct packed {
        logic [ADDR_W-TAG_LSB-1:0] p;   // physical tag
        logic                      rp;  // readable
    } cache_tag_t;

    typedef struct packed {
        logic [WID_W-1:0]  wid;
        logic [STRB_W-1:0] strb;     // nonzero means store
        logic [1:0]        msize;    // size minus one
        logic              msigned;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;    // already placed on its byte lanes
    } lsu_req_t;

    typedef struct packed {
        logic [WID_W-1:0]  wid;
        logic [DATA_W-1:0] rdata;    // zero for stores
        logic [ADDR_W-1:0] addr;
        logic              ale;      // misaligned
    } lsu_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   wdata;
        logic [NUM_WAYS-1:0] way;    // one-hot hit way
        logic                hit;
    } sb_entry_t;

    typedef struct packed {
        lsu_req_t                        req;
        logic [NUM_WAYS-1:0]             rhit;
        logic [NUM_WAYS-1:0][DATA_W-1:0] data;
        logic [SB_DEPTH-1:0]             sb_hit;
        logic                            ale;
    } m1_pack_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } bus_req_t;

    typedef struct packed {
        logic              ready;    // also qualifies rdata
        logic [DATA_W-1:0] rdata;
    } bus_resp_t;

    typedef struct packed {
        logic      valid;
        sb_entry_t entry;
    } sb_wb_t;

endpackage

// ==== rtl/lsu_store_buffer.sv ====
// in-order store queue; push is trusted (caller checks full) and commit on an empty buffer is illegal
`timescale 1ns/1ns

module lsu_store_buffer (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       push_i,
    input  lsu_pkg::sb_entry_t                         push_entry_i,
    input  logic                                       commit_i,
    output logic                                       full_o,
    output lsu_pkg::sb_entry_t [lsu_pkg::SB_DEPTH-1:0] entries_o,
    output logic [lsu_pkg::SB_DEPTH-1:0]               valid_o,
    output lsu_pkg::sb_wb_t                            sb_wb_o
);

    lsu_pkg::sb_entry_t [lsu_pkg::SB_DEPTH-1:0] entry_q;
    logic [lsu_pkg::SB_DEPTH-1:0]               valid_q;
    logic [lsu_pkg::SB_PTR_W-1:0]               head_q;  // oldest
    logic [lsu_pkg::SB_PTR_W-1:0]               tail_q;  // next free
    logic [lsu_pkg::SB_PTR_W:0]                 count_q;

    assign full_o    = (count_q == (lsu_pkg::SB_PTR_W+1)'(lsu_pkg::SB_DEPTH));
    assign entries_o = entry_q;
    assign valid_o   = valid_q;

    // write-back leaves in the commit cycle itself
    assign sb_wb_o.valid = commit_i;
    assign sb_wb_o.entry = entry_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            if (push_i) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (commit_i) begin
                valid_q[head_q] <= 1'b0;  // never the slot being pushed
                head_q          <= head_q + 1'b1;
            end
            case ({push_i, commit_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entry_q[tail_q] <= push_entry_i;
        end
    end

endmodule

// ==== rtl/lsu_top.sv ====
// cached loads and stores only; uncached access, cache ops, barriers and store-miss refill not supported
`timescale 1ns/1ns

module lsu_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              lsu_req_valid_i,
    output logic                                              lsu_req_ready_o,
    input  lsu_pkg::lsu_req_t                                 lsu_req_i,
    output logic                                              lsu_resp_valid_o,
    input  logic                                              lsu_resp_ready_i,
    output lsu_pkg::lsu_resp_t                                lsu_resp_o,
    output logic [lsu_pkg::OFFSET_W-1:0]                      sram_addr_o,
    input  lsu_pkg::cache_tag_t [lsu_pkg::NUM_WAYS-1:0]       sram_tag_i,
    input  logic [lsu_pkg::NUM_WAYS-1:0][lsu_pkg::DATA_W-1:0] sram_data_i,
    output lsu_pkg::bus_req_t                                 bus_req_o,
    input  lsu_pkg::bus_resp_t                                bus_resp_i,
    input  logic                                              commit_i,
    output lsu_pkg::sb_wb_t                                   sb_wb_o
);

    logic                                       m1_valid;
    lsu_pkg::m1_pack_t                          m1_pack;
    logic                                       m2_ready;
    logic                                       sb_full;
    lsu_pkg::sb_entry_t [lsu_pkg::SB_DEPTH-1:0] sb_entries;
    logic [lsu_pkg::SB_DEPTH-1:0]               sb_valid;
    logic                                       sb_push;
    lsu_pkg::sb_entry_t                         sb_push_entry;

    lsu_m1_stage i_m1_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .lsu_req_valid_i (lsu_req_valid_i),
        .lsu_req_ready_o (lsu_req_ready_o),
        .lsu_req_i       (lsu_req_i),
        .sram_addr_o     (sram_addr_o),
        .sram_tag_i      (sram_tag_i),
        .sram_data_i     (sram_data_i),
        .m2_ready_i      (m2_ready),
        .sb_entries_i    (sb_entries),
        .sb_valid_i      (sb_valid),
        .m1_valid_o      (m1_valid),
        .m1_o            (m1_pack)
    );

    lsu_store_buffer i_store_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (sb_push),
        .push_entry_i (sb_push_entry),
        .commit_i     (commit_i),
        .full_o       (sb_full),
        .entries_o    (sb_entries),
        .valid_o      (sb_valid),
        .sb_wb_o      (sb_wb_o)
    );

    lsu_m2_ctrl i_m2_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .m1_valid_i       (m1_valid),
        .m1_i             (m1_pack),
        .sb_full_i        (sb_full),
        .sb_entries_i     (sb_entries),
        .sb_valid_i       (sb_valid),
        .commit_i         (commit_i),
        .lsu_resp_ready_i (lsu_resp_ready_i),
        .bus_resp_i       (bus_resp_i),
        .m2_ready_o       (m2_ready),
        .sb_push_o        (sb_push),
        .sb_push_entry_o  (sb_push_entry),
        .lsu_resp_valid_o (lsu_resp_valid_o),
        .lsu_resp_o       (lsu_resp_o),
        .bus_req_o        (bus_req_o)
    );

endmodule

// ==== verif/lsu_checker.sv ====
// handshake and write-back properties; active outside reset, bound onto lsu_top
`timescale 1ns/1ns

module lsu_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               lsu_req_valid_i,
    input logic               lsu_req_ready_o,
    input lsu_pkg::lsu_req_t  lsu_req_i,
    input logic               lsu_resp_valid_o,
    input logic               lsu_resp_ready_i,
    input lsu_pkg::lsu_resp_t lsu_resp_o,
    input lsu_pkg::bus_req_t  bus_req_o,
    input lsu_pkg::bus_resp_t bus_resp_i,
    input lsu_pkg::sb_wb_t    sb_wb_o
);

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req_valid_i && !lsu_req_ready_o |=> lsu_req_valid_i && $stable(lsu_req_i))
        else $error("request valid or payload changed before acceptance");

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_resp_valid_o && !lsu_resp_ready_i |=> lsu_resp_valid_o && $stable(lsu_resp_o))
        else $error("response changed while stalled");

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_o.valid && !bus_resp_i.ready |=> bus_req_o.valid && $stable(bus_req_o.addr))
        else $error("bus request dropped before ready");

    // only stores enter the buffer, so a retired entry has a nonzero strobe
    a_wb_store: assert property (@(posedge clk) disable iff (!rst_n)
        sb_wb_o.valid |-> (|sb_wb_o.entry.strb))
        else $error("write-back carries no buffered store");

endmodule

// ==== verif/lsu_tb.sv ====
// directed tests; SRAM content and bus refill words are fixed functions of the address
`timescale 1ns/1ns

module lsu_tb;

    localparam int TIMEOUT = 1000;  // cycles per wait loop

    logic clk = 1'b0;
    logic rst_n;
    logic lsu_req_valid_i, lsu_req_ready_o, lsu_resp_valid_o, lsu_resp_ready_i, commit_i;
    lsu_pkg::lsu_req_t  lsu_req_i;
    lsu_pkg::lsu_resp_t lsu_resp_o;
    logic [lsu_pkg::OFFSET_W-1:0] sram_addr_o;
    lsu_pkg::cache_tag_t [lsu_pkg::NUM_WAYS-1:0] sram_tag_i;
    logic [lsu_pkg::NUM_WAYS-1:0][lsu_pkg::DATA_W-1:0] sram_data_i;
    lsu_pkg::bus_req_t  bus_req_o;
    lsu_pkg::bus_resp_t bus_resp_i;
    lsu_pkg::sb_wb_t    sb_wb_o;

    lsu_pkg::cache_tag_t tag_mem [lsu_pkg::NUM_WAYS][256];
    lsu_pkg::lsu_resp_t  exp_q[$];
    lsu_pkg::sb_entry_t  sb_model[$];   // stores not yet committed, oldest first
    logic [31:0]         bus_addr_q[$];
    int                  acc_q[$];
    logic [31:0] hit_base [4] = '{32'h0001_2340, 32'h0005_6780, 32'h000a_bc00, 32'h0003_3f00};
    logic [31:0] miss_base = 32'h0007_7440;
    logic [31:0] lfsr_q = 32'hac5d_a708;
    int cyc = 0, last_lat = 0, mismatches = 0, errors = 0, bus_wait = 0;
    logic bp_on = 1'b0, bus_busy = 1'b0;
    logic [5:0] wid_n = '0;

    lsu_top i_lsu_top (.*);

    bind lsu_top lsu_checker i_checker (.*);

    always #4 clk = ~clk;

    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // x^32+x^22+x^2+x+1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_rand_bit()};
        return v;
    endfunction

    function automatic logic [31:0] sram_word(int w, logic [11:0] off);
        return {4'hc, w[1:0], off[11:2], ~off[11:2], 6'h15};
    endfunction

    function automatic logic [31:0] bus_word(logic [31:0] a);
        return ~{a[15:0], a[31:16]} ^ 32'h3c3c_0f0f;
    endfunction

    function automatic int find_way(logic [31:0] a);
        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++) begin
            if (tag_mem[w][a[11:4]].rp && tag_mem[w][a[11:4]].p == a[31:12]) return w;
        end
        return -1;
    endfunction

    function automatic logic misaligned(lsu_pkg::lsu_req_t r);
        return (r.msize == 2'd1) ? r.addr[0] : (r.msize == 2'd2) ? |r.addr[1:0] : 1'b0;
    endfunction

    // reference: pick word, overlay pending store bytes, shift down, extend
    function automatic lsu_pkg::lsu_resp_t expect_resp(lsu_pkg::lsu_req_t r);
        lsu_pkg::lsu_resp_t e;
        logic [31:0] word;
        int w;
        e.wid  = r.wid;
        e.addr = r.addr;
        e.ale  = misaligned(r);
        w      = find_way(r.addr);
        word   = (w >= 0) ? sram_word(w, r.addr[11:0]) : (e.ale ? 32'h0 : bus_word(r.addr));
        foreach (sb_model[i]) begin
            if (sb_model[i].addr[31:2] == r.addr[31:2]) begin
                for (int b = 0; b < 4; b++)
                    if (sb_model[i].strb[b]) word[8*b +: 8] = sb_model[i].wdata[8*b +: 8];
            end
        end
        word = word >> (8 * r.addr[1:0]);
        if (r.msize == 2'd0) e.rdata = {{24{r.msigned & word[7]}}, word[7:0]};
        else if (r.msize == 2'd1) e.rdata = {{16{r.msigned & word[15]}}, word[15:0]};
        else e.rdata = word;
        if (|r.strb) e.rdata = '0;
        return e;
    endfunction

    task automatic check_resp(lsu_pkg::lsu_resp_t got, lsu_pkg::lsu_resp_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: lsu_resp_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_wb(lsu_pkg::sb_wb_t got, lsu_pkg::sb_wb_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: sb_wb_o got %h expected %h", $time, got, exp);
        end
    endtask

    // SRAMs with registered outputs
    always @(posedge clk) begin
        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++) begin
            sram_tag_i[w]  <= tag_mem[w][sram_addr_o[11:4]];
            sram_data_i[w] <= sram_word(w, sram_addr_o);
        end
    end

    // response monitor, also counts edges
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n && lsu_resp_valid_o && lsu_resp_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t with no request outstanding", $time);
            end else begin
                check_resp(lsu_resp_o, exp_q.pop_front());
                last_lat = cyc - acc_q.pop_front();
            end
        end
    end

    // bus model and response back-pressure, both change on the falling edge
    always @(negedge clk) begin
        lsu_resp_ready_i = bp_on ? next_rand_bit() : 1'b1;
        if (bus_resp_i.ready) begin
            bus_resp_i = '0;  // one-cycle answer
        end else if (rst_n && bus_req_o.valid) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                bus_wait = 1 + int'(rand_bits(3));
                bus_addr_q.push_back(bus_req_o.addr);
            end
            bus_wait--;
            if (bus_wait == 0) begin
                bus_resp_i.ready = 1'b1;
                bus_resp_i.rdata = bus_word(bus_req_o.addr);
                bus_busy         = 1'b0;
            end
        end
    end

    // drives on the falling edge, returns at the accepting rising edge; valid stays up
    task automatic send_req(logic [3:0] strb, logic [1:0] sz, logic sgn, logic [31:0] a,
                            logic [31:0] wdata);
        lsu_pkg::lsu_req_t r;
        lsu_pkg::sb_entry_t e;
        int n, w;
        r = '{wid: wid_n, strb: strb, msize: sz, msigned: sgn, addr: a, wdata: wdata};
        wid_n++;
        exp_q.push_back(expect_resp(r));
        if (|strb && !misaligned(r)) begin
            w = find_way(a);
            e = '{addr: a, strb: strb, wdata: wdata, way: '0, hit: (w >= 0)};
            if (w >= 0) e.way[w] = 1'b1;
            sb_model.push_back(e);
        end
        @(negedge clk);
        lsu_req_valid_i = 1'b1;
        lsu_req_i       = r;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!lsu_req_ready_o && n < TIMEOUT);
        if (!lsu_req_ready_o) begin
            errors++;
            $display("request not accepted within %0d cycles at %0t", TIMEOUT, $time);
        end
        acc_q.push_back(cyc);
    endtask

    task automatic drop_req();
        @(negedge clk);
        lsu_req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        drop_req();
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses missing after %0d cycles", exp_q.size(), TIMEOUT);
            exp_q.delete();
            acc_q.delete();
        end
    endtask

    task automatic commit_one();
        lsu_pkg::sb_wb_t exp;
        if (sb_model.size() == 0) begin
            errors++;
            $display("commit requested with no store outstanding");
        end else begin
            exp.valid = 1'b1;
            exp.entry = sb_model.pop_front();
            @(negedge clk);
            commit_i = 1'b1;
            @(posedge clk);
            check_wb(sb_wb_o, exp);
            @(negedge clk);
            commit_i = 1'b0;
        end
    endtask

    task automatic test_load_hit();
        for (int sz = 0; sz < 3; sz++)
            for (int sg = 0; sg < 2; sg++)
                for (int off = 0; off < 4; off += (1 << sz)) begin
                    send_req(4'h0, 2'(sz), 1'(sg), hit_base[off] + 32'(off + 4), '0);
                    wait_drain();
                    if (last_lat != 4) begin  // valid after edge t+3, taken at t+4
                        mismatches++;
                        $display("Mismatch at %0t: latency got %0d expected 4", $time, last_lat);
                    end
                end
    endtask

    task automatic test_misaligned();
        bus_addr_q.delete();
        send_req(4'h0, 2'd1, 1'b1, hit_base[0] + 32'h1, '0);
        send_req(4'h0, 2'd1, 1'b0, hit_base[1] + 32'h7, '0);
        send_req(4'h0, 2'd2, 1'b0, hit_base[2] + 32'h2, '0);
        send_req(4'h0, 2'd2, 1'b0, miss_base + 32'h3, '0);
        send_req(4'b1100, 2'd2, 1'b0, hit_base[3] + 32'h1, 32'h1234_5678);
        wait_drain();
        if (bus_addr_q.size() != 0) begin
            errors++;
            $display("misaligned access produced a bus request");
        end
    endtask

    task automatic test_refill();
        logic [31:0] a;
        bus_addr_q.delete();
        for (int i = 0; i < 4; i++) begin
            a = miss_base + 32'(i * 4 + (i & 2));
            send_req(4'h0, (i == 0) ? 2'd2 : 2'd1, 1'(i), a, '0);
            wait_drain();
            if (bus_addr_q.size() != 1 || bus_addr_q[0] !== a) begin
                mismatches++;
                $display("Mismatch at %0t: bus_req_o.addr got %0d requests, first %h expected %h",
                         $time, bus_addr_q.size(), bus_addr_q[0], a);
            end
            bus_addr_q.delete();
        end
    endtask

    task automatic test_forward();
        send_req(4'b0010, 2'd0, 1'b0, hit_base[1] + 32'h5, 32'h0000_a500);
        send_req(4'h0, 2'd2, 1'b0, hit_base[1] + 32'h4, '0);
        send_req(4'b1100, 2'd1, 1'b0, hit_base[2] + 32'ha, 32'h8e71_0000);
        send_req(4'h0, 2'd1, 1'b1, hit_base[2] + 32'ha, '0);
        send_req(4'h0, 2'd2, 1'b0, hit_base[2] + 32'h8, '0);
        wait_drain();
        commit_one();
        commit_one();
    endtask

    task automatic test_overlap();
        send_req(4'b0011, 2'd1, 1'b0, hit_base[3], 32'h0000_beef);
        wait_drain();
        send_req(4'b1111, 2'd2, 1'b0, hit_base[3], 32'hcafe_f00d);
        drop_req();
        repeat (12) @(posedge clk);
        if (exp_q.size() != 1) begin
            errors++;
            $display("overlapping store answered before its commit");
        end
        commit_one();
        wait_drain();
        commit_one();
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        int sz;
        bp_on = 1'b1;
        for (int i = 0; i < 24; i++) begin
            if (i == 7 || i == 15) begin
                send_req(4'b1111, 2'd2, 1'b0, hit_base[i % 4] + 32'h100 + 32'(4 * i), 32'(i));
            end else begin
                a  = next_rand_bit() ? hit_base[rand_bits(2)] : miss_base;
                sz = int'(rand_bits(2));
                if (sz == 3) sz = 2;
                a[3:0] = rand_bits(4);
                if (sz == 1) a[0] = 1'b0;
                if (sz == 2) a[1:0] = 2'b00;
                send_req(4'h0, 2'(sz), next_rand_bit(), a, '0);
            end
        end
        wait_drain();
        bp_on = 1'b0;
        commit_one();
        commit_one();
        bus_addr_q.delete();
    endtask

    initial begin
        rst_n           = 1'b0;
        lsu_req_valid_i = 1'b0;
        lsu_req_i       = '0;
        lsu_resp_ready_i = 1'b1;
        commit_i        = 1'b0;
        bus_resp_i      = '0;
        sram_tag_i      = '0;
        sram_data_i     = '0;
        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++)
            for (int i = 0; i < 256; i++) tag_mem[w][i] = '0;
        for (int w = 0; w < lsu_pkg::NUM_WAYS; w++)
            tag_mem[w][hit_base[w][11:4]] = '{p: hit_base[w][31:12], rp: 1'b1};
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_load_hit();
        test_misaligned();
        test_refill();
        test_forward();
        test_overlap();
        test_backpressure();
        repeat (4) @(posedge clk);
        $display("checks done: %0d mismatches, %0d other errors", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
